// File: cache_pkg.sv
/* shared widths, request structs and enums of the write-through cache */
`default_nettype none

package cache_pkg;

   localparam int ADDR_W = 12;
   localparam int DATA_W = 32;
   localparam int NBYTES = 4;
   localparam int NBYTES_W = $clog2(NBYTES);

   // byte address bit that selects the control registers
   localparam int CTRL_BIT = 11;
   localparam int CTRL_ADDR_W = 3;

   // word address keeps the byte address numbering
   typedef struct packed {
      logic [ADDR_W-1:NBYTES_W] addr;
      logic [DATA_W-1:0]        wdata;
      logic [NBYTES-1:0]        wstrb;
   } fe_req_t;

   typedef struct packed {
      logic [ADDR_W-1:NBYTES_W] addr;
      logic [DATA_W-1:0]        wdata;
      logic [NBYTES-1:0]        wstrb;
      logic                     we;
   } mem_req_t;

   // word offsets inside control space
   typedef enum logic [CTRL_ADDR_W-1:0] {
      REG_READ_HIT    = 3'd0,
      REG_READ_MISS   = 3'd1,
      REG_WRITE_HIT   = 3'd2,
      REG_WRITE_MISS  = 3'd3,
      REG_WTBUF_EMPTY = 3'd4,
      REG_INVALIDATE  = 3'd5
   } ctrl_reg_e;

   typedef enum logic [1:0] {
      IDLE,
      WAIT_WTB,
      FILL,
      DONE
   } mem_state_e;

endpackage

`default_nettype wire

// File: cache_front_end.sv
/* front end: request register and steering between data and control paths */
`default_nettype none

module cache_front_end (
   input  logic                            clk_i,
   input  logic                            reset_i,
   input  logic                            valid_i,
   input  cache_pkg::fe_req_t              req_i,
   output logic                            ready_o,
   output logic                            rvalid_o,
   output logic [cache_pkg::DATA_W-1:0]    rdata_o,
   output logic                            data_valid_o,
   output cache_pkg::fe_req_t              data_req_o,
   input  logic                            data_ack_i,
   input  logic [cache_pkg::DATA_W-1:0]    data_rdata_i,
   output logic                            ctrl_valid_o,
   output cache_pkg::ctrl_reg_e            ctrl_addr_o,
   output logic [cache_pkg::DATA_W-1:0]    ctrl_wdata_o,
   input  logic                            ctrl_ack_i,
   input  logic [cache_pkg::DATA_W-1:0]    ctrl_rdata_i
);

   cache_pkg::fe_req_t req_q;
   logic               busy_q;
   logic               accept;
   logic               ack;
   logic               wr;

   assign accept = valid_i && ready_o;
   assign ack = data_ack_i || ctrl_ack_i;
   assign wr = |req_q.wstrb;

   // next request may enter in the cycle of the response
   assign ready_o = !busy_q || ack;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         busy_q <= 1'b0;
         data_valid_o <= 1'b0;
         ctrl_valid_o <= 1'b0;
      end else begin
         data_valid_o <= accept && !req_i.addr[cache_pkg::CTRL_BIT];
         ctrl_valid_o <= accept && req_i.addr[cache_pkg::CTRL_BIT];
         if (accept) begin
            busy_q <= 1'b1;
         end else if (ack) begin
            busy_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         req_q <= req_i;
      end
   end

   assign data_req_o = req_q;
   assign ctrl_addr_o = cache_pkg::ctrl_reg_e'(req_q.addr[cache_pkg::NBYTES_W +:
                                                         cache_pkg::CTRL_ADDR_W]);
   // reads never carry data into control space
   assign ctrl_wdata_o = wr ? req_q.wdata : '0;

   assign rvalid_o = ack;
   // writes answer with zero
   assign rdata_o = wr ? '0 : (data_ack_i ? data_rdata_i : ctrl_rdata_i);

endmodule

`default_nettype wire

// File: cache_memory.sv
/* cache memory: tag, valid and data arrays, hit check,
   line fill and write-through pushes */
`default_nettype none

module cache_memory #(
   parameter int NLINES_W      = 4,
   parameter int WORD_OFFSET_W = 2
) (
   input  logic                         clk_i,
   input  logic                         reset_i,
   input  logic                         data_valid_i,
   input  cache_pkg::fe_req_t           data_req_i,
   output logic                         data_ack_o,
   output logic [cache_pkg::DATA_W-1:0] data_rdata_o,
   input  logic                         wtbuf_full_i,
   input  logic                         wtbuf_empty_i,
   output logic                         push_o,
   output cache_pkg::mem_req_t          push_req_o,
   output logic                         fill_valid_o,
   output logic [cache_pkg::ADDR_W-cache_pkg::NBYTES_W-WORD_OFFSET_W-1:0] fill_addr_o,
   input  logic                         fill_word_valid_i,
   input  logic [cache_pkg::DATA_W-1:0] fill_word_i,
   input  logic                         fill_done_i,
   output logic                         read_hit_o,
   output logic                         read_miss_o,
   output logic                         write_hit_o,
   output logic                         write_miss_o,
   input  logic                         invalidate_i
);

   localparam int LINE_W = cache_pkg::ADDR_W - cache_pkg::NBYTES_W - WORD_OFFSET_W;
   localparam int TAG_W = LINE_W - NLINES_W;
   localparam int WIDX_W = NLINES_W + WORD_OFFSET_W;

   cache_pkg::mem_state_e        state_q;
   logic [TAG_W-1:0]             tag_mem [2**NLINES_W];
   logic [cache_pkg::DATA_W-1:0] data_mem [2**WIDX_W];
   logic [2**NLINES_W-1:0]       valid_q;
   logic [WORD_OFFSET_W-1:0]     fill_off_q;
   logic [WIDX_W-1:0]            word_idx;
   logic [NLINES_W-1:0]          index;
   logic [TAG_W-1:0]             tag;
   logic                         we;
   logic                         hit;
   logic                         req_new;

   assign word_idx = data_req_i.addr[cache_pkg::NBYTES_W +: WIDX_W];
   assign index = word_idx[WORD_OFFSET_W +: NLINES_W];
   assign tag = data_req_i.addr[cache_pkg::ADDR_W-1 -: TAG_W];
   assign we = |data_req_i.wstrb;
   assign hit = valid_q[index] && (tag_mem[index] == tag);
   assign req_new = (state_q == cache_pkg::IDLE) && data_valid_i;

   // every write goes to the buffer once a slot is free
   assign push_o = we && !wtbuf_full_i && (req_new || state_q == cache_pkg::WAIT_WTB);
   assign push_req_o = '{addr: data_req_i.addr, wdata: data_req_i.wdata,
                         wstrb: data_req_i.wstrb, we: 1'b1};

   assign fill_valid_o = (state_q == cache_pkg::FILL);
   assign fill_addr_o = data_req_i.addr[cache_pkg::ADDR_W-1 -: LINE_W];

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= cache_pkg::IDLE;
         valid_q <= '0;
         fill_off_q <= '0;
         data_ack_o <= 1'b0;
         read_hit_o <= 1'b0;
         read_miss_o <= 1'b0;
         write_hit_o <= 1'b0;
         write_miss_o <= 1'b0;
      end else begin
         data_ack_o <= 1'b0;
         read_hit_o <= req_new && !we && hit;
         read_miss_o <= req_new && !we && !hit;
         write_hit_o <= req_new && we && hit;
         write_miss_o <= req_new && we && !hit;
         if (invalidate_i) begin
            valid_q <= '0;
         end
         case (state_q)
            cache_pkg::IDLE: begin
               if (data_valid_i) begin
                  if (push_o || (!we && hit)) begin
                     data_ack_o <= 1'b1;
                  end else begin
                     state_q <= cache_pkg::WAIT_WTB;
                  end
               end
            end
            cache_pkg::WAIT_WTB: begin
               // writes wait for a slot, read misses for an empty buffer
               if (push_o) begin
                  data_ack_o <= 1'b1;
                  state_q <= cache_pkg::IDLE;
               end else if (!we && wtbuf_empty_i) begin
                  state_q <= cache_pkg::FILL;
               end
            end
            cache_pkg::FILL: begin
               if (fill_word_valid_i) begin
                  fill_off_q <= fill_off_q + 1'b1;
               end
               if (fill_done_i) begin
                  valid_q[index] <= 1'b1;
                  state_q <= cache_pkg::DONE;
               end
            end
            default: begin
               data_ack_o <= 1'b1;
               state_q <= cache_pkg::IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (req_new && hit) begin
         // merge strobed bytes into the cached word
         for (int b = 0; b < cache_pkg::NBYTES; b++) begin
            if (data_req_i.wstrb[b]) begin
               data_mem[word_idx][8*b +: 8] <= data_req_i.wdata[8*b +: 8];
            end
         end
         data_rdata_o <= data_mem[word_idx];
      end
      if (state_q == cache_pkg::FILL && fill_word_valid_i) begin
         data_mem[{index, fill_off_q}] <= fill_word_i;
      end
      if (state_q == cache_pkg::FILL && fill_done_i) begin
         tag_mem[index] <= tag;
      end
      if (state_q == cache_pkg::DONE) begin
         data_rdata_o <= data_mem[word_idx];
      end
   end

endmodule

`default_nettype wire

// File: cache_wtbuf.sv
/* write-through buffer: circular FIFO of pending memory writes */
`default_nettype none

module cache_wtbuf #(
   parameter int WTBUF_DEPTH_W = 2
) (
   input  logic                clk_i,
   input  logic                reset_i,
   input  logic                push_i,
   input  cache_pkg::mem_req_t push_req_i,
   input  logic                pop_i,
   output cache_pkg::mem_req_t head_o,
   output logic                full_o,
   output logic                empty_o
);

   localparam int DEPTH = 2**WTBUF_DEPTH_W;

   cache_pkg::mem_req_t      fifo_q [DEPTH];
   logic [WTBUF_DEPTH_W-1:0] wr_ptr_q;
   logic [WTBUF_DEPTH_W-1:0] rd_ptr_q;
   logic [WTBUF_DEPTH_W:0]   count_q;
   logic                     do_push;
   logic                     do_pop;

   assign full_o = (count_q == (WTBUF_DEPTH_W+1)'(DEPTH));
   assign empty_o = (count_q == '0);
   assign do_push = push_i && !full_o;
   assign do_pop = pop_i && !empty_o;
   assign head_o = fifo_q[rd_ptr_q];

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10: count_q <= count_q + 1'b1;
            2'b01: count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (do_push) begin
         fifo_q[wr_ptr_q] <= push_req_i;
      end
   end

endmodule

`default_nettype wire

// File: cache_back_end.sv
/* back end: single-beat memory port shared by buffered writes and line fills */
`default_nettype none

module cache_back_end #(
   parameter int WORD_OFFSET_W = 2
) (
   input  logic                         clk_i,
   input  logic                         reset_i,
   input  cache_pkg::mem_req_t          wtbuf_head_i,
   input  logic                         wtbuf_empty_i,
   output logic                         wtbuf_pop_o,
   input  logic                         fill_valid_i,
   input  logic [cache_pkg::ADDR_W-cache_pkg::NBYTES_W-WORD_OFFSET_W-1:0] fill_addr_i,
   output logic                         fill_word_valid_o,
   output logic [cache_pkg::DATA_W-1:0] fill_word_o,
   output logic                         fill_done_o,
   output logic                         mem_valid_o,
   output cache_pkg::mem_req_t          mem_req_o,
   input  logic                         mem_ready_i,
   input  logic [cache_pkg::DATA_W-1:0] mem_rdata_i
);

   logic                     fill_busy_q;
   logic [WORD_OFFSET_W-1:0] word_q;
   logic                     xfer_done;
   logic                     launch_wr;
   logic                     launch_rd;

   assign xfer_done = mem_valid_o && mem_ready_i;

   // pending writes go first, a fill only starts on an empty buffer
   assign launch_wr = !mem_valid_o && !fill_busy_q && !wtbuf_empty_i;
   assign launch_rd = !mem_valid_o && (fill_busy_q || (wtbuf_empty_i && fill_valid_i));

   // entry leaves the buffer only once memory has taken it
   assign wtbuf_pop_o = xfer_done && !fill_busy_q;

   assign fill_word_valid_o = xfer_done && fill_busy_q;
   assign fill_word_o = mem_rdata_i;
   assign fill_done_o = fill_word_valid_o && (word_q == '1);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         mem_valid_o <= 1'b0;
         fill_busy_q <= 1'b0;
         word_q <= '0;
      end else begin
         if (launch_wr || launch_rd) begin
            mem_valid_o <= 1'b1;
         end else if (xfer_done) begin
            mem_valid_o <= 1'b0;
         end
         if (launch_rd) begin
            fill_busy_q <= 1'b1;
         end else if (fill_done_o) begin
            fill_busy_q <= 1'b0;
         end
         // wraps back to zero after the last word
         if (fill_word_valid_o) begin
            word_q <= word_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (launch_wr) begin
         mem_req_o <= wtbuf_head_i;
      end else if (launch_rd) begin
         mem_req_o <= '{addr: {fill_addr_i, word_q}, wdata: '0, wstrb: '0, we: 1'b0};
      end
   end

endmodule

`default_nettype wire

// File: cache_control.sv
/* control block: hit/miss counters, buffer status and invalidate command */
`default_nettype none

module cache_control (
   input  logic                         clk_i,
   input  logic                         reset_i,
   input  logic                         ctrl_valid_i,
   input  cache_pkg::ctrl_reg_e         ctrl_addr_i,
   input  logic [cache_pkg::DATA_W-1:0] ctrl_wdata_i,
   output logic                         ctrl_ack_o,
   output logic [cache_pkg::DATA_W-1:0] ctrl_rdata_o,
   input  logic                         read_hit_i,
   input  logic                         read_miss_i,
   input  logic                         write_hit_i,
   input  logic                         write_miss_i,
   input  logic                         wtbuf_empty_i,
   output logic                         invalidate_o
);

   logic [3:0]                         events;
   logic [3:0][cache_pkg::DATA_W-1:0] cnt_q;
   logic                               inv_cmd;

   // ordered like the counter register addresses
   assign events = {write_miss_i, write_hit_i, read_miss_i, read_hit_i};

   // bit 0 of a write to REG_INVALIDATE starts the flush
   assign inv_cmd = ctrl_valid_i && (ctrl_addr_i == cache_pkg::REG_INVALIDATE) &&
                    ctrl_wdata_i[0];

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         ctrl_ack_o <= 1'b0;
         invalidate_o <= 1'b0;
         cnt_q <= '0;
      end else begin
         ctrl_ack_o <= ctrl_valid_i;
         invalidate_o <= inv_cmd;
         for (int i = 0; i < 4; i++) begin
            if (inv_cmd) begin
               cnt_q[i] <= '0;
            end else if (events[i] && (cnt_q[i] != '1)) begin
               cnt_q[i] <= cnt_q[i] + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (ctrl_valid_i) begin
         case (ctrl_addr_i)
            cache_pkg::REG_READ_HIT,
            cache_pkg::REG_READ_MISS,
            cache_pkg::REG_WRITE_HIT,
            cache_pkg::REG_WRITE_MISS: ctrl_rdata_o <= cnt_q[ctrl_addr_i[1:0]];
            cache_pkg::REG_WTBUF_EMPTY: ctrl_rdata_o <= {{(cache_pkg::DATA_W-1){1'b0}},
                                                         wtbuf_empty_i};
            default: ctrl_rdata_o <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: cache_top.sv
/* cache top level: front end, cache memory, write buffer, back end and control */
`default_nettype none

module cache_top #(
   parameter int NLINES_W      = 4,
   parameter int WORD_OFFSET_W = 2,
   parameter int WTBUF_DEPTH_W = 2
) (
   input  logic                         clk_i,
   input  logic                         reset_i,
   input  logic                         valid_i,
   input  cache_pkg::fe_req_t           req_i,
   output logic                         ready_o,
   output logic                         rvalid_o,
   output logic [cache_pkg::DATA_W-1:0] rdata_o,
   output logic                         mem_valid_o,
   output cache_pkg::mem_req_t          mem_req_o,
   input  logic                         mem_ready_i,
   input  logic [cache_pkg::DATA_W-1:0] mem_rdata_i
);

   localparam int LINE_W = cache_pkg::ADDR_W - cache_pkg::NBYTES_W - WORD_OFFSET_W;

   cache_pkg::fe_req_t           data_req;
   cache_pkg::ctrl_reg_e         ctrl_addr;
   cache_pkg::mem_req_t          push_req;
   cache_pkg::mem_req_t          wtbuf_head;
   logic                         data_valid, data_ack, ctrl_valid, ctrl_ack;
   logic [cache_pkg::DATA_W-1:0] data_rdata, ctrl_rdata, ctrl_wdata, fill_word;
   logic                         push, pop, wtbuf_full, wtbuf_empty;
   logic                         fill_valid, fill_word_valid, fill_done;
   logic [LINE_W-1:0]            fill_addr;
   logic                         read_hit, read_miss, write_hit, write_miss, invalidate;

   cache_front_end u_front_end (
      .clk_i(clk_i), .reset_i(reset_i),
      .valid_i(valid_i), .req_i(req_i),
      .ready_o(ready_o), .rvalid_o(rvalid_o), .rdata_o(rdata_o),
      .data_valid_o(data_valid), .data_req_o(data_req),
      .data_ack_i(data_ack), .data_rdata_i(data_rdata),
      .ctrl_valid_o(ctrl_valid), .ctrl_addr_o(ctrl_addr), .ctrl_wdata_o(ctrl_wdata),
      .ctrl_ack_i(ctrl_ack), .ctrl_rdata_i(ctrl_rdata)
   );

   cache_memory #(
      .NLINES_W(NLINES_W), .WORD_OFFSET_W(WORD_OFFSET_W)
   ) u_cache_memory (
      .clk_i(clk_i), .reset_i(reset_i),
      .data_valid_i(data_valid), .data_req_i(data_req),
      .data_ack_o(data_ack), .data_rdata_o(data_rdata),
      .wtbuf_full_i(wtbuf_full), .wtbuf_empty_i(wtbuf_empty),
      .push_o(push), .push_req_o(push_req),
      .fill_valid_o(fill_valid), .fill_addr_o(fill_addr),
      .fill_word_valid_i(fill_word_valid), .fill_word_i(fill_word),
      .fill_done_i(fill_done),
      .read_hit_o(read_hit), .read_miss_o(read_miss),
      .write_hit_o(write_hit), .write_miss_o(write_miss),
      .invalidate_i(invalidate)
   );

   cache_wtbuf #(
      .WTBUF_DEPTH_W(WTBUF_DEPTH_W)
   ) u_wtbuf (
      .clk_i(clk_i), .reset_i(reset_i),
      .push_i(push), .push_req_i(push_req), .pop_i(pop),
      .head_o(wtbuf_head), .full_o(wtbuf_full), .empty_o(wtbuf_empty)
   );

   cache_back_end #(
      .WORD_OFFSET_W(WORD_OFFSET_W)
   ) u_back_end (
      .clk_i(clk_i), .reset_i(reset_i),
      .wtbuf_head_i(wtbuf_head), .wtbuf_empty_i(wtbuf_empty), .wtbuf_pop_o(pop),
      .fill_valid_i(fill_valid), .fill_addr_i(fill_addr),
      .fill_word_valid_o(fill_word_valid), .fill_word_o(fill_word),
      .fill_done_o(fill_done),
      .mem_valid_o(mem_valid_o), .mem_req_o(mem_req_o),
      .mem_ready_i(mem_ready_i), .mem_rdata_i(mem_rdata_i)
   );

   cache_control u_control (
      .clk_i(clk_i), .reset_i(reset_i),
      .ctrl_valid_i(ctrl_valid), .ctrl_addr_i(ctrl_addr), .ctrl_wdata_i(ctrl_wdata),
      .ctrl_ack_o(ctrl_ack), .ctrl_rdata_o(ctrl_rdata),
      .read_hit_i(read_hit), .read_miss_i(read_miss),
      .write_hit_i(write_hit), .write_miss_i(write_miss),
      .wtbuf_empty_i(wtbuf_empty), .invalidate_o(invalidate)
   );

endmodule

`default_nettype wire

// File: tb_mem_model.sv
/* behavioral main memory for the cache testbench, with random ready delays */
`default_nettype none

module tb_mem_model (
   input  logic                         clk_i,
   input  logic                         reset_i,
   input  logic                         hold_i,
   input  logic                         mem_valid_i,
   input  cache_pkg::mem_req_t          mem_req_i,
   output logic                         mem_ready_o,
   output logic [cache_pkg::DATA_W-1:0] mem_rdata_o
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int WORDS = 2**(cache_pkg::ADDR_W - cache_pkg::NBYTES_W);

   logic [cache_pkg::DATA_W-1:0] mem [WORDS];
   integer                       seed;
   logic                         next_ready;
   int                           w;
   int                           b;

   initial begin
      seed = 32'h6af5;
      mem_ready_o = 1'b0;
      mem_rdata_o = '0;
      // each word holds its byte address xor a fixed marker
      for (w = 0; w < WORDS; w++) begin
         mem[w] = (w * cache_pkg::NBYTES) ^ 32'hA5A50000;
      end
   end

   always @(posedge clk_i) begin
      if (mem_valid_i && mem_ready_o && mem_req_i.we) begin
         for (b = 0; b < cache_pkg::NBYTES; b++) begin
            if (mem_req_i.wstrb[b]) begin
               mem[mem_req_i.addr][8*b +: 8] <= mem_req_i.wdata[8*b +: 8];
            end
         end
      end
      // ready roughly three cycles in four unless held off
      next_ready = !reset_i && !hold_i && (($random(seed) & 3) != 0);
      #1;
      mem_ready_o = next_ready;
      if (mem_valid_i && !mem_req_i.we) begin
         mem_rdata_o = mem[mem_req_i.addr];
      end else begin
         mem_rdata_o = '0;
      end
   end

endmodule

`default_nettype wire

// File: tb_cache.sv
/* cache testbench: clock, reset, reference model, directed tests, checker and watchdog */
`default_nettype none

module tb_cache;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NLINES_W = 4;
   localparam int WORD_OFFSET_W = 2;
   localparam int WTBUF_DEPTH_W = 2;
   localparam int DEPTH = 2**WTBUF_DEPTH_W;
   localparam int WADDR_W = cache_pkg::ADDR_W - cache_pkg::NBYTES_W;
   localparam int WORDS = 2**WADDR_W;
   // all five tests together need well under two thousand cycles
   localparam int MAX_CYCLES = 20000;

   typedef logic [cache_pkg::ADDR_W-1:0] addr_t;

   logic                clk = 1'b0;
   logic                reset;
   logic                valid;
   cache_pkg::fe_req_t  req;
   logic                ready;
   logic                rvalid;
   logic [31:0]         rdata;
   logic                mem_valid;
   cache_pkg::mem_req_t mem_req;
   logic                mem_ready;
   logic [31:0]         mem_rdata;
   logic                mem_hold;

   // expected memory image and direct-mapped tag state
   logic [31:0]        ref_mem [WORDS];
   logic               line_valid [2**NLINES_W];
   int                 line_tag [2**NLINES_W];
   // read hit, read miss, write hit, write miss
   int                 exp_cnt [4];
   logic [WADDR_W-1:0] log_addr [$];
   logic [31:0]        log_data [$];
   logic [WADDR_W-1:0] exp_addr [$];
   logic [31:0]        exp_data [$];
   int                 errors = 0;
   int                 checks = 0;
   int                 cycles = 0;

   cache_top #(
      .NLINES_W(NLINES_W), .WORD_OFFSET_W(WORD_OFFSET_W), .WTBUF_DEPTH_W(WTBUF_DEPTH_W)
   ) u_cache_top (
      .clk_i(clk), .reset_i(reset),
      .valid_i(valid), .req_i(req), .ready_o(ready),
      .rvalid_o(rvalid), .rdata_o(rdata),
      .mem_valid_o(mem_valid), .mem_req_o(mem_req),
      .mem_ready_i(mem_ready), .mem_rdata_i(mem_rdata)
   );

   tb_mem_model u_mem_model (
      .clk_i(clk), .reset_i(reset), .hold_i(mem_hold),
      .mem_valid_i(mem_valid), .mem_req_i(mem_req),
      .mem_ready_o(mem_ready), .mem_rdata_o(mem_rdata)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycles == MAX_CYCLES) begin
         $display("run stopped after %0d cycles without finishing", MAX_CYCLES);
         $display("Regression failed");
         $finish;
      end
   end

   // completed memory writes in the order the port saw them
   always @(posedge clk) begin
      if (!reset && mem_valid && mem_ready && mem_req.we) begin
         log_addr.push_back(mem_req.addr);
         log_data.push_back(mem_req.wdata);
      end
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      end
   endtask

   function automatic int index_of(input addr_t addr);
      return (addr >> (cache_pkg::NBYTES_W + WORD_OFFSET_W)) % (2**NLINES_W);
   endfunction

   function automatic int tag_of(input addr_t addr);
      return addr >> (cache_pkg::NBYTES_W + WORD_OFFSET_W + NLINES_W);
   endfunction

   function automatic logic cached(input addr_t addr);
      return line_valid[index_of(addr)] && (line_tag[index_of(addr)] == tag_of(addr));
   endfunction

   function automatic addr_t ctrl_addr(input cache_pkg::ctrl_reg_e sel);
      addr_t a;
      a = '0;
      a[cache_pkg::CTRL_BIT] = 1'b1;
      a[cache_pkg::NBYTES_W +: cache_pkg::CTRL_ADDR_W] = sel;
      return a;
   endfunction

   // called 1 ns after an edge, returns 1 ns after the accepting edge
   task automatic send_req(input addr_t addr, input logic [31:0] wdata,
                           input logic [3:0] wstrb);
      valid = 1'b1;
      req = '{addr: addr[cache_pkg::ADDR_W-1:cache_pkg::NBYTES_W], wdata: wdata, wstrb: wstrb};
      @(posedge clk);
      while (!ready) begin
         @(posedge clk);
      end
      #1;
      valid = 1'b0;
   endtask

   task automatic wait_resp(output logic [31:0] rd, output int lat);
      lat = 0;
      do begin
         @(posedge clk);
         lat++;
      end while (!rvalid);
      rd = rdata;
      #1;
   endtask

   task automatic note_write(input addr_t addr, input logic [31:0] wdata,
                             input logic [3:0] wstrb);
      int b;
      for (b = 0; b < cache_pkg::NBYTES; b++) begin
         if (wstrb[b]) begin
            ref_mem[addr >> cache_pkg::NBYTES_W][8*b +: 8] = wdata[8*b +: 8];
         end
      end
      // writes never allocate
      if (cached(addr)) begin
         exp_cnt[2]++;
      end else begin
         exp_cnt[3]++;
      end
      exp_addr.push_back(addr >> cache_pkg::NBYTES_W);
      exp_data.push_back(wdata);
   endtask

   task automatic data_write(input addr_t addr, input logic [31:0] wdata,
                             input logic [3:0] wstrb);
      logic [31:0] rd;
      int          lat;
      note_write(addr, wdata, wstrb);
      send_req(addr, wdata, wstrb);
      wait_resp(rd, lat);
      check_value("rdata_o on write", rd, 32'h0);
   endtask

   task automatic data_read(input addr_t addr);
      logic [31:0] rd;
      int          lat;
      logic        hit;
      hit = cached(addr);
      send_req(addr, '0, '0);
      wait_resp(rd, lat);
      check_value($sformatf("rdata_o at %03h", addr), rd, ref_mem[addr >> cache_pkg::NBYTES_W]);
      if (hit) begin
         exp_cnt[0]++;
         check_value("read hit latency", lat, 2);
      end else begin
         exp_cnt[1]++;
         line_valid[index_of(addr)] = 1'b1;
         line_tag[index_of(addr)] = tag_of(addr);
      end
   endtask

   task automatic ctrl_read(input cache_pkg::ctrl_reg_e sel, output logic [31:0] val);
      int lat;
      send_req(ctrl_addr(sel), '0, '0);
      wait_resp(val, lat);
      check_value("control read latency", lat, 2);
   endtask

   task automatic check_counters();
      string       names [4] = '{"read hit count", "read miss count",
                                 "write hit count", "write miss count"};
      logic [31:0] val;
      int          r;
      for (r = 0; r < 4; r++) begin
         ctrl_read(cache_pkg::ctrl_reg_e'(r), val);
         check_value(names[r], val, exp_cnt[r]);
      end
   endtask

   task automatic wait_wtbuf_empty();
      logic [31:0] val;
      int          polls;
      val = '0;
      polls = 0;
      while (val != 1 && polls < 200) begin
         ctrl_read(cache_pkg::REG_WTBUF_EMPTY, val);
         polls++;
      end
      if (val != 1) begin
         errors++;
         $display("write buffer still not empty after %0d status reads", polls);
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      $display("test %-14s done, %0d errors", name, errors - errs_before);
   endtask

   task automatic test_reset();
      logic [31:0] val;
      int          e;
      e = errors;
      @(posedge clk);
      check_value("ready_o", ready, 1);
      check_value("rvalid_o", rvalid, 0);
      check_value("mem_valid_o", mem_valid, 0);
      #1;
      check_counters();
      ctrl_read(cache_pkg::REG_WTBUF_EMPTY, val);
      check_value("wtbuf empty flag", val, 1);
      report_test("reset", e);
   endtask

   task automatic test_read_fill();
      int e;
      int w;
      e = errors;
      // first word misses and fills the line, the rest hit
      for (w = 0; w < 2**WORD_OFFSET_W; w++) begin
         data_read(12'h040 + cache_pkg::NBYTES * w);
      end
      data_read(12'h040);
      check_counters();
      report_test("read_fill", e);
   endtask

   task automatic test_strobes();
      addr_t addrs [3] = '{12'h044, 12'h048, 12'h300};
      int    e;
      int    i;
      e = errors;
      data_write(addrs[0], 32'h11223344, 4'b0101);
      data_write(addrs[1], 32'hAABBCCDD, 4'b1000);
      data_write(addrs[2], 32'h55667788, 4'b0011);
      wait_wtbuf_empty();
      for (i = 0; i < 3; i++) begin
         check_value($sformatf("memory word at %03h", addrs[i]),
                     u_mem_model.mem[addrs[i] >> cache_pkg::NBYTES_W],
                     ref_mem[addrs[i] >> cache_pkg::NBYTES_W]);
         data_read(addrs[i]);
      end
      check_counters();
      report_test("strobes", e);
   endtask

   task automatic test_backpressure();
      logic [31:0] rd;
      int          lat;
      int          e;
      int          i;
      addr_t       a;
      e = errors;
      log_addr.delete();
      log_data.delete();
      exp_addr.delete();
      exp_data.delete();
      mem_hold = 1'b1;
      repeat (2) @(posedge clk);
      #1;
      for (i = 0; i < DEPTH; i++) begin
         data_write(12'h200 + cache_pkg::NBYTES * i, 32'hC0DE0000 + i, 4'hF);
      end
      // buffer is full, this write has to wait
      a = 12'h200 + cache_pkg::NBYTES * DEPTH;
      note_write(a, 32'hC0DE0000 + DEPTH, 4'hF);
      send_req(a, 32'hC0DE0000 + DEPTH, 4'hF);
      repeat (20) begin
         @(posedge clk);
         check_value("ready_o", ready, 0);
         check_value("rvalid_o", rvalid, 0);
      end
      #1;
      mem_hold = 1'b0;
      wait_resp(rd, lat);
      check_value("rdata_o on write", rd, 32'h0);
      for (i = DEPTH + 1; i < DEPTH + 4; i++) begin
         data_write(12'h200 + cache_pkg::NBYTES * i, 32'hC0DE0000 + i, 4'hF);
      end
      wait_wtbuf_empty();
      check_value("memory write count", log_addr.size(), exp_addr.size());
      for (i = 0; i < exp_addr.size() && i < log_addr.size(); i++) begin
         check_value($sformatf("mem_req_o.addr of write %0d", i), log_addr[i], exp_addr[i]);
         check_value($sformatf("mem_req_o.wdata of write %0d", i), log_data[i], exp_data[i]);
         check_value($sformatf("memory word %03h", exp_addr[i]),
                     u_mem_model.mem[exp_addr[i]], ref_mem[exp_addr[i]]);
      end
      report_test("backpressure", e);
   endtask

   task automatic test_invalidate();
      logic [31:0] rd;
      int          lat;
      int          e;
      int          i;
      e = errors;
      send_req(ctrl_addr(cache_pkg::REG_INVALIDATE), 32'h1, 4'hF);
      wait_resp(rd, lat);
      check_value("rdata_o on invalidate", rd, 32'h0);
      for (i = 0; i < 2**NLINES_W; i++) begin
         line_valid[i] = 1'b0;
      end
      for (i = 0; i < 4; i++) begin
         exp_cnt[i] = 0;
      end
      check_counters();
      // line 4 was cached before, so this misses and refills
      data_read(12'h044);
      data_read(12'h048);
      check_counters();
      report_test("invalidate", e);
   endtask

   initial begin
      int n;
      reset = 1'b1;
      valid = 1'b0;
      req = '0;
      mem_hold = 1'b0;
      for (n = 0; n < WORDS; n++) begin
         ref_mem[n] = (n * cache_pkg::NBYTES) ^ 32'hA5A50000;
      end
      for (n = 0; n < 2**NLINES_W; n++) begin
         line_valid[n] = 1'b0;
         line_tag[n] = 0;
      end
      for (n = 0; n < 4; n++) begin
         exp_cnt[n] = 0;
      end
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;
      test_reset();
      test_read_fill();
      test_strobes();
      test_backpressure();
      test_invalidate();
      $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: build.f
cache_pkg.sv
cache_front_end.sv
cache_memory.sv
cache_wtbuf.sv
cache_back_end.sv
cache_control.sv
cache_top.sv
tb_mem_model.sv
tb_cache.sv
